/* src/clear_redraw_pkg.sv */
`default_nettype none

package clear_redraw_pkg;

	// board geometry
	localparam int BOARD_COLS = 4;
	localparam int BOARD_ROWS_DEFAULT = 8;

	// one row of cells, bit 0 is the leftmost column
	typedef logic [BOARD_COLS-1:0] row_t;

	// codes 3, 5, 6 and 7 are treated like a landing
	typedef enum logic [2:0]
	{
		PH_GEN      = 3'd0,
		PH_MOVE     = 3'd1,
		PH_LAND     = 3'd2,
		PH_NEWBOARD = 3'd4
	} phase_t;

	typedef enum logic [1:0]
	{
		PC_SINGLE = 2'd0,
		PC_DOMINO = 2'd1,
		PC_SQUARE = 2'd2,
		PC_ELL    = 2'd3
	} piece_t;

	// spawn window covers the top two rows
	localparam int SPAWN_COL = 1;
	localparam int SPAWN_ROWS = 2;
	localparam int SPAWN_WIDTH = 2;

	// window bit is window row * SPAWN_WIDTH + window column
	typedef logic [SPAWN_ROWS*SPAWN_WIDTH-1:0] window_t;

	// single cell at the spawn column
	localparam window_t SHAPE_SINGLE = 4'b0001;
	localparam window_t SHAPE_DOMINO = 4'b0011;
	localparam window_t SHAPE_SQUARE = 4'b1111;
	// one cell on top, two below
	localparam window_t SHAPE_ELL    = 4'b1101;

	function automatic window_t spawn_shape(piece_t piece);
		window_t shape;
		case (piece)
			PC_SINGLE: shape = SHAPE_SINGLE;
			PC_DOMINO: shape = SHAPE_DOMINO;
			PC_SQUARE: shape = SHAPE_SQUARE;
			PC_ELL:    shape = SHAPE_ELL;
			default:   shape = '0;
		endcase
		return shape;
	endfunction

endpackage

`default_nettype wire

/* src/piece_spawner.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_spawner
	import clear_redraw_pkg::*;
#(
	parameter int ROWS = BOARD_ROWS_DEFAULT
)
(
	input  wire logic [ROWS*BOARD_COLS-1:0] board_in,
	input  wire piece_t                     piece,
	output logic [ROWS*BOARD_COLS-1:0]      spawn_board,
	output logic                            spawn_error
);

	window_t                    shape;
	logic [ROWS*BOARD_COLS-1:0] piece_mask;

	assign shape = spawn_shape(piece);

	// place the window shape into a full-size board mask
	always_comb
	begin
		piece_mask = '0;
		for (int r = 0; r < SPAWN_ROWS; r++)
		begin
			for (int c = 0; c < SPAWN_WIDTH; c++)
			begin
				piece_mask[r*BOARD_COLS + SPAWN_COL + c] = shape[r*SPAWN_WIDTH + c];
			end
		end
	end

	assign spawn_board = board_in | piece_mask;

	// collision when any new cell is already taken
	assign spawn_error = |(board_in & piece_mask);

endmodule

`default_nettype wire

/* src/row_compactor.sv */
`timescale 1ns/1ps
`default_nettype none

module row_compactor
	import clear_redraw_pkg::*;
#(
	parameter int ROWS = BOARD_ROWS_DEFAULT
)
(
	input  wire logic [ROWS*BOARD_COLS-1:0] board_in,
	output logic [ROWS*BOARD_COLS-1:0]      cleared_board
);

	logic [ROWS-1:0] row_full;

	// full row detect, one flag per row
	always_comb
	begin
		for (int r = 0; r < ROWS; r++)
		begin
			row_full[r] = &board_in[r*BOARD_COLS +: BOARD_COLS];
		end
	end

	// walk from the bottom row (highest index) up to row 0
	// surviving rows stack onto the bottom of the output
	// rows never written stay empty and form the new top
	always_comb
	begin
		int   dst;
		row_t src_row;

		cleared_board = '0;
		dst = ROWS - 1;
		for (int r = ROWS - 1; r >= 0; r--)
		begin
			src_row = board_in[r*BOARD_COLS +: BOARD_COLS];
			if (!row_full[r])
			begin
				cleared_board[dst*BOARD_COLS +: BOARD_COLS] = src_row;
				dst = dst - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/board_register.sv */
`timescale 1ns/1ps
`default_nettype none

module board_register
	import clear_redraw_pkg::*;
#(
	parameter int ROWS = BOARD_ROWS_DEFAULT
)
(
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       in_valid,
	input  wire phase_t                     phase,
	input  wire logic [ROWS*BOARD_COLS-1:0] board_in,
	input  wire logic [ROWS*BOARD_COLS-1:0] spawn_board,
	input  wire logic                       spawn_error,
	input  wire logic [ROWS*BOARD_COLS-1:0] cleared_board,
	output logic                            out_valid,
	output logic [ROWS*BOARD_COLS-1:0]      board_out,
	output logic                            error
);

	logic [ROWS*BOARD_COLS-1:0] sel_board;
	logic                       sel_error;

	// stage 1 holds the selected result of the job
	logic                       s1_valid;
	logic [ROWS*BOARD_COLS-1:0] s1_board;
	logic                       s1_error;

	// result select by phase
	always_comb
	begin
		case (phase)
			PH_GEN:
			begin
				sel_board = spawn_board;
				sel_error = spawn_error;
			end
			PH_MOVE:
			begin
				sel_board = board_in;
				sel_error = 1'b0;
			end
			PH_NEWBOARD:
			begin
				sel_board = '0;
				sel_error = 1'b0;
			end
			default:
			begin
				// landing and every unlisted code
				sel_board = cleared_board;
				sel_error = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_board <= sel_board;
			s1_error <= sel_error;
		end
	end

	// stage 2 drives the outputs
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			board_out <= '0;
			error <= 1'b0;
		end
		else
		begin
			out_valid <= s1_valid;
			if (s1_valid)
			begin
				board_out <= s1_board;
				error <= s1_error;
			end
		end
	end

endmodule

`default_nettype wire

/* src/clear_redraw.sv */
`timescale 1ns/1ps
`default_nettype none

module clear_redraw
	import clear_redraw_pkg::*;
#(
	parameter int ROWS = BOARD_ROWS_DEFAULT
)
(
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       in_valid,
	input  wire logic [ROWS*BOARD_COLS-1:0] board_in,
	input  wire phase_t                     phase,
	input  wire piece_t                     piece,
	output logic                            out_valid,
	output logic [ROWS*BOARD_COLS-1:0]      board_out,
	output logic                            error
);

	// spawn path
	logic [ROWS*BOARD_COLS-1:0] spawn_board;
	logic                       spawn_error;

	// line clear path
	logic [ROWS*BOARD_COLS-1:0] cleared_board;

	piece_spawner #(
		.ROWS(ROWS)
	) u_piece_spawner (
		.board_in   (board_in),
		.piece      (piece),
		.spawn_board(spawn_board),
		.spawn_error(spawn_error)
	);

	row_compactor #(
		.ROWS(ROWS)
	) u_row_compactor (
		.board_in     (board_in),
		.cleared_board(cleared_board)
	);

	// both paths are combinational, the result is picked and held here
	board_register #(
		.ROWS(ROWS)
	) u_board_register (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.phase        (phase),
		.board_in     (board_in),
		.spawn_board  (spawn_board),
		.spawn_error  (spawn_error),
		.cleared_board(cleared_board),
		.out_valid    (out_valid),
		.board_out    (board_out),
		.error        (error)
	);

endmodule

`default_nettype wire

/* include/tb_board_model.svh */
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// model boards use the default geometry
typedef logic [BOARD_ROWS_DEFAULT*BOARD_COLS-1:0] model_board_t;

// cells of each piece as listed by cell index
function automatic model_board_t model_mask(piece_t piece);
	model_board_t mask;
	mask = '0;
	case (piece)
		PC_SINGLE: mask[1] = 1'b1;
		PC_DOMINO:
		begin
			mask[1] = 1'b1;
			mask[2] = 1'b1;
		end
		PC_SQUARE:
		begin
			mask[1] = 1'b1;
			mask[2] = 1'b1;
			mask[5] = 1'b1;
			mask[6] = 1'b1;
		end
		default:
		begin
			mask[1] = 1'b1;
			mask[5] = 1'b1;
			mask[6] = 1'b1;
		end
	endcase
	return mask;
endfunction

// removes full rows one at a time, from the top down
function automatic model_board_t model_compact(model_board_t board);
	model_board_t result;
	result = board;
	for (int r = 0; r < BOARD_ROWS_DEFAULT; r++)
	begin
		if (&result[r*BOARD_COLS +: BOARD_COLS])
		begin
			for (int k = r; k > 0; k--)
				result[k*BOARD_COLS +: BOARD_COLS] = result[(k-1)*BOARD_COLS +: BOARD_COLS];
			result[0 +: BOARD_COLS] = '0;
		end
	end
	return result;
endfunction

// expected board and error of one job
function automatic model_board_t model_result(phase_t ph, model_board_t board,
		piece_t piece, output logic err);
	model_board_t mask;
	mask = model_mask(piece);
	err = 1'b0;
	case (ph)
		PH_GEN:
		begin
			err = |(board & mask);
			return board | mask;
		end
		PH_MOVE:     return board;
		PH_NEWBOARD: return '0;
		default:     return model_compact(board);
	endcase
endfunction

`endif

/* tb/tb_clear_redraw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clear_redraw
	import clear_redraw_pkg::*;
;

	`include "tb_board_model.svh"

	// job counts of each test group
	localparam int N_SPAWN_RANDOM = 200;
	localparam int N_MOVE = 200;
	localparam int N_LAND_RANDOM = 300;
	localparam int N_NEWBOARD = 50;
	localparam int N_GAP_JOBS = 250;
	localparam int MAX_GAP = 3;

	// reset, fixed jobs and drain on top of the random groups
	localparam int TEST_CYCLES = 40 + N_SPAWN_RANDOM + N_MOVE + N_LAND_RANDOM + N_NEWBOARD
		+ N_GAP_JOBS * (MAX_GAP + 1);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 400;

	logic         clk;
	logic         rst_n;
	logic         in_valid;
	model_board_t board_in;
	phase_t       phase;
	piece_t       piece;
	logic         out_valid;
	model_board_t board_out;
	logic         error;

	integer seed;
	int     value_errors;
	int     strobe_errors;
	int     jobs_sent;
	int     jobs_seen;
	int     cycle_count;

	// expected results with the oldest job first
	model_board_t exp_board_q[$];
	logic         exp_error_q[$];
	model_board_t chk_board;
	logic         chk_error;

	clear_redraw #(
		.ROWS(BOARD_ROWS_DEFAULT)
	) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.board_in (board_in),
		.phase    (phase),
		.piece    (piece),
		.out_valid(out_valid),
		.board_out(board_out),
		.error    (error)
	);

	always #5 clk = ~clk;

	// outputs stay cleared while reset is held
	assert property (@(posedge clk) !rst_n |-> (!out_valid && !error && board_out == '0))
	else
	begin
		$display("mismatch reset outputs out_valid %h error %h board_out %h",
			out_valid, error, board_out);
		value_errors++;
	end

	// output strobe follows the input strobe by exactly two cycles
	assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2))
	else
	begin
		$display("out_valid did not follow in_valid by exactly two cycles at %0t", $time);
		strobe_errors++;
	end

	// compare each result with the oldest outstanding job
	always @(posedge clk)
	begin
		if (rst_n && out_valid)
		begin
			if (exp_board_q.size() == 0)
			begin
				$display("output strobe seen with no job outstanding at %0t", $time);
				strobe_errors++;
			end
			else
			begin
				chk_board = exp_board_q.pop_front();
				chk_error = exp_error_q.pop_front();
				jobs_seen++;
				assert (board_out == chk_board)
				else
				begin
					$display("mismatch board_out expected %h got %h", chk_board, board_out);
					value_errors++;
				end
				assert (error == chk_error)
				else
				begin
					$display("mismatch error expected %h got %h", chk_error, error);
					value_errors++;
				end
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing the tests", cycle_count);
		$display("Something failed");
		$finish;
	end

	// called 1 ns after an edge and returns 1 ns after the sampling edge
	task automatic send_job(input phase_t ph, input model_board_t board, input piece_t pc);
		model_board_t exp_b;
		logic         exp_e;
		exp_b = model_result(ph, board, pc, exp_e);
		exp_board_q.push_back(exp_b);
		exp_error_q.push_back(exp_e);
		in_valid = 1'b1;
		board_in = board;
		phase = ph;
		piece = pc;
		jobs_sent++;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
		end
		#1;
	endtask

	// outputs read zero right after reset is released
	task automatic check_cleared_outputs();
		assert (!out_valid && !error && board_out == '0)
		else
		begin
			$display("mismatch after reset out_valid %h error %h board_out %h",
				out_valid, error, board_out);
			value_errors++;
		end
	endtask

	// random board with a random set of rows forced full
	task automatic make_land_board(output model_board_t board);
		logic [31:0] rnd;
		board = $random(seed);
		rnd = $random(seed);
		for (int r = 0; r < BOARD_ROWS_DEFAULT; r++)
		begin
			if (rnd[2*r +: 2] == 2'b00)
				board[r*BOARD_COLS +: BOARD_COLS] = '1;
		end
	endtask

	initial
	begin
		logic [31:0]  rnd;
		model_board_t board;
		logic [2:0]   land_codes [0:4];

		seed = 55526;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		board_in = '0;
		phase = PH_MOVE;
		piece = PC_SINGLE;
		value_errors = 0;
		strobe_errors = 0;
		jobs_sent = 0;
		jobs_seen = 0;
		land_codes[0] = 3'd2;
		land_codes[1] = 3'd3;
		land_codes[2] = 3'd5;
		land_codes[3] = 3'd6;
		land_codes[4] = 3'd7;

		repeat (4)
		begin
			@(posedge clk);
		end
		#1;
		rst_n = 1'b1;
		idle_cycles(1);
		check_cleared_outputs();

		// each piece alone on an empty board
		for (int p = 0; p < 4; p++)
			send_job(PH_GEN, '0, piece_t'(p[1:0]));

		// sparse boards with the top rows sometimes cleared so both error values occur
		for (int i = 0; i < N_SPAWN_RANDOM; i++)
		begin
			rnd = $random(seed);
			board = $random(seed) & $random(seed);
			if (rnd[2])
				board[7:0] = '0;
			send_job(PH_GEN, board, piece_t'(rnd[1:0]));
		end

		// reset again while the outputs hold a colliding spawn result
		send_job(PH_GEN, '1, PC_SINGLE);
		while (exp_board_q.size() != 0)
		begin
			@(posedge clk);
		end
		idle_cycles(1);
		rst_n = 1'b0;
		idle_cycles(4);
		rst_n = 1'b1;
		idle_cycles(1);
		check_cleared_outputs();

		for (int i = 0; i < N_MOVE; i++)
		begin
			rnd = $random(seed);
			send_job(PH_MOVE, $random(seed), piece_t'(rnd[1:0]));
		end

		// no full row, one, two adjacent, three, alternating, all full, empty
		send_job(PH_LAND, 32'h12345678, PC_SINGLE);
		send_job(PH_LAND, 32'h1234F678, PC_SINGLE);
		send_job(PH_LAND, 32'h12FF5678, PC_DOMINO);
		send_job(PH_LAND, 32'hF2FF5678, PC_SQUARE);
		send_job(PH_LAND, 32'hF0F0F0F0, PC_ELL);
		send_job(PH_LAND, 32'h5F7F3F1F, PC_SINGLE);
		send_job(PH_LAND, 32'hFFFFFFFF, PC_SINGLE);
		send_job(PH_LAND, 32'h00000000, PC_SINGLE);
		send_job(phase_t'(3'd3), 32'hFF00FF00, PC_SINGLE);
		send_job(phase_t'(3'd7), 32'h0FFFF0F0, PC_SINGLE);

		for (int i = 0; i < N_LAND_RANDOM; i++)
		begin
			make_land_board(board);
			rnd = $random(seed);
			send_job(phase_t'(land_codes[i % 5]), board, piece_t'(rnd[1:0]));
		end

		for (int i = 0; i < N_NEWBOARD; i++)
		begin
			rnd = $random(seed);
			board = $random(seed);
			send_job(PH_NEWBOARD, board | 32'h1, piece_t'(rnd[1:0]));
		end

		// mixed phases with random gaps between jobs
		for (int i = 0; i < N_GAP_JOBS; i++)
		begin
			rnd = $random(seed);
			if (rnd[2:0] == 3'd2)
				make_land_board(board);
			else
				board = $random(seed);
			send_job(phase_t'(rnd[2:0]), board, piece_t'(rnd[4:3]));
			if (rnd[6:5] != 2'd0)
				idle_cycles(int'(rnd[6:5]));
		end

		while (exp_board_q.size() != 0)
		begin
			@(posedge clk);
		end
		idle_cycles(4);

		if (jobs_seen != jobs_sent)
		begin
			$display("%0d jobs were sent but %0d results came out", jobs_sent, jobs_seen);
			strobe_errors++;
		end

		$display("value errors %0d, strobe errors %0d, jobs sent %0d, results seen %0d",
			value_errors, strobe_errors, jobs_sent, jobs_seen);
		if (value_errors == 0 && strobe_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
src/clear_redraw_pkg.sv
src/piece_spawner.sv
src/row_compactor.sv
src/board_register.sv
src/clear_redraw.sv
tb/tb_clear_redraw.sv

/* run.sh */
#!/bin/sh
# build and run the clear_redraw testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module tb_clear_redraw \
	-f sim.f \
	-o tb_clear_redraw

./obj_dir/tb_clear_redraw > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0
